// File: hw/lq_pkg.sv
// shared load queue types; 32-bit data only, one return port, sizes follow the funct3 load encoding
package lq_pkg;

  // data word carried by results, returns and the register file forward
  typedef logic [31:0] word_t;

  // access size as taken from the load funct3, with fp16 on the spare code
  typedef enum logic [2:0] {
    LQ_SZ_B    = 3'd0, // byte, sign extended
    LQ_SZ_H    = 3'd1, // halfword, sign extended
    LQ_SZ_W    = 3'd2, // full word
    LQ_SZ_BU   = 3'd4, // byte, zero extended
    LQ_SZ_HU   = 3'd5, // halfword, zero extended
    LQ_SZ_H_FP = 3'd6  // fp16, NaN boxed into 32 bits
  } lq_size_e;

  // per-entry tag written at allocation
  typedef struct packed {
    logic       load; // entry waits for a memory return
    logic [4:0] rd;   // destination register
  } lq_info_t;

  // access details recorded by the execute write of a load
  typedef struct packed {
    lq_size_e   size;
    logic [1:0] addr_lo; // byte offset within the word
  } lq_acc_t;

  // memory return bundle
  // the entry index travels beside it since its width follows the depth
  typedef struct packed {
    logic  vld;
    logic  cancel; // late kill, arrives with vld
    word_t data;   // raw word as read, not yet aligned
  } lq_ret_t;

endpackage

// File: hw/lq_ptrs.sv
// head and tail pointers; LQ_DEPTH must be a power of two, the caller never overflows or underflows
module lq_ptrs #(
  parameter int LQ_DEPTH = 8,
  parameter int IDX_W    = $clog2(LQ_DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_alloc,   // push at tail
  input  logic             i_retire,  // pop at head
  output logic [IDX_W-1:0] o_wr_idx,
  output logic [IDX_W-1:0] o_rd_idx,
  output logic             o_full,
  output logic             o_empty
);

  // one extra bit so that full and empty can be told apart
  logic [IDX_W:0] wr_ptr_q;
  logic [IDX_W:0] rd_ptr_q;
  logic           idx_equal;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (i_alloc) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (i_retire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  assign idx_equal = (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]);
  assign o_empty   = idx_equal & (wr_ptr_q[IDX_W] == rd_ptr_q[IDX_W]);
  assign o_full    = idx_equal & (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]); // tail lapped the head

  assign o_wr_idx = wr_ptr_q[IDX_W-1:0];
  assign o_rd_idx = rd_ptr_q[IDX_W-1:0];

  // an allocation while full would overwrite the head entry
  a_alloc_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> !o_full)
    else $error("allocation while load queue is full");

  // a retire while empty would walk the head past the tail
  a_retire_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_retire |-> !o_empty)
    else $error("retire while load queue is empty");

endmodule

// File: hw/lq_entry_fsm.sv
// per-entry lifecycle; loads become ready only by a return fill, retire wins over any same-cycle event
module lq_entry_fsm import lq_pkg::*; #(
  parameter int LQ_DEPTH = 8,
  parameter int IDX_W    = $clog2(LQ_DEPTH)
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_alloc,
  input  logic [IDX_W-1:0]    i_wr_idx,
  input  logic                i_retire,
  input  logic [IDX_W-1:0]    i_rd_idx,
  input  logic                i_alloc_is_load,
  input  logic                i_ex_vld,
  input  logic [IDX_W-1:0]    i_ex_id,
  input  logic                i_ret_fill,      // live return that is written, not bypassed
  input  logic [IDX_W-1:0]    i_ret_id,
  output logic [LQ_DEPTH-1:0] o_valid,
  output logic [LQ_DEPTH-1:0] o_ready,
  output logic [LQ_DEPTH-1:0] o_is_load
);

  typedef enum logic [1:0] {
    ST_FREE  = 2'd0,
    ST_WAIT  = 2'd1, // allocated, result not yet known
    ST_READY = 2'd2  // result held in the result store
  } state_e;

  state_e              state_q [LQ_DEPTH];
  state_e              state_d [LQ_DEPTH];
  logic [LQ_DEPTH-1:0] load_q;
  logic [LQ_DEPTH-1:0] load_d;

  always_comb begin
    for (int e = 0; e < LQ_DEPTH; e++) begin
      state_d[e] = state_q[e];
      load_d[e]  = load_q[e];
      if (i_retire && (i_rd_idx == IDX_W'(e))) begin
        state_d[e] = ST_FREE; // also covers a head that was bypassed while waiting
      end else if (i_alloc && (i_wr_idx == IDX_W'(e))) begin
        state_d[e] = ST_WAIT;
        load_d[e]  = i_alloc_is_load;
      end else if (state_q[e] == ST_WAIT) begin
        if (i_ex_vld && (i_ex_id == IDX_W'(e)) && !load_q[e]) begin
          state_d[e] = ST_READY; // non-load result delivered by execute
        end
        if (i_ret_fill && (i_ret_id == IDX_W'(e)) && load_q[e]) begin
          state_d[e] = ST_READY;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      for (int e = 0; e < LQ_DEPTH; e++) begin
        state_q[e] <= ST_FREE;
      end
      load_q <= '0;
    end else begin
      state_q <= state_d;
      load_q  <= load_d;
    end
  end

  for (genvar e = 0; e < LQ_DEPTH; e++) begin : g_out
    assign o_valid[e] = (state_q[e] != ST_FREE);
    assign o_ready[e] = (state_q[e] == ST_READY);
  end
  assign o_is_load = load_q;

  // execute and memory may only target entries handed out by allocation
  a_ex_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex_vld |-> (state_q[i_ex_id] != ST_FREE))
    else $error("execute write to free entry %0d", i_ex_id);

  a_fill_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ret_fill |-> (state_q[i_ret_id] != ST_FREE))
    else $error("return fill to free entry %0d", i_ret_id);

  // the return path only fills loads
  a_fill_nonload: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ret_fill |-> load_q[i_ret_id])
    else $error("return fill to non-load entry %0d", i_ret_id);

endmodule

// File: hw/lq_store.sv
// multi-port entry array without reset; contents are only meaningful once an entry has been written
module lq_store import lq_pkg::*; #(
  parameter type ENTRY_T  = word_t,
  parameter int  NUM_WR   = 1,
  parameter int  LQ_DEPTH = 8,
  parameter int  IDX_W    = $clog2(LQ_DEPTH)
) (
  input  logic                         i_clk,
  input  logic   [NUM_WR-1:0]          i_wr_en,
  input  logic   [NUM_WR-1:0][IDX_W-1:0] i_wr_idx,
  input  ENTRY_T [NUM_WR-1:0]          i_wr_value,
  output ENTRY_T [LQ_DEPTH-1:0]        o_entries  // whole array, read combinationally
);

  ENTRY_T [LQ_DEPTH-1:0] mem_q;

  // higher port index is applied last and wins on a clash
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < NUM_WR; p++) begin
      if (i_wr_en[p]) begin
        mem_q[i_wr_idx[p]] <= i_wr_value[p];
      end
    end
  end

  assign o_entries = mem_q;

  // producers on different ports target disjoint entries in any one cycle
  for (genvar p = 0; p < NUM_WR; p++) begin : g_port_a
    for (genvar q = p + 1; q < NUM_WR; q++) begin : g_port_b
      a_wr_clash: assert property (@(posedge i_clk)
        (i_wr_en[p] && i_wr_en[q]) |-> (i_wr_idx[p] != i_wr_idx[q]))
        else $error("ports %0d and %0d write entry %0d together", p, q, i_wr_idx[p]);
    end
  end

endmodule

// File: hw/lq_return.sv
// load return datapath, purely combinational; a bypassed head return is lost unless retired that cycle
module lq_return import lq_pkg::*; #(
  parameter int LQ_DEPTH = 8,
  parameter int IDX_W    = $clog2(LQ_DEPTH)
) (
  input  lq_ret_t                 i_ret,
  input  logic    [IDX_W-1:0]     i_ret_id,
  input  logic                    i_bypass_disable,
  input  logic    [IDX_W-1:0]     i_rd_idx,    // head entry
  input  logic    [LQ_DEPTH-1:0]  i_is_load,
  input  logic    [LQ_DEPTH-1:0]  i_ready,
  input  lq_acc_t [LQ_DEPTH-1:0]  i_acc,
  input  word_t   [LQ_DEPTH-1:0]  i_results,
  output logic                    o_fill,
  output logic    [IDX_W-1:0]     o_fill_id,
  output word_t                   o_fill_data,
  output logic                    o_lq_data_ready,
  output word_t                   o_lq_rddata,
  output logic                    o_lq_fwdvld,
  output logic    [IDX_W-1:0]     o_lq_fwdid,
  output word_t                   o_lq_fwddata
);

  logic    ret_live;
  logic    ret_is_load;
  logic    ret_at_head;
  logic    bypass;
  lq_acc_t ret_acc;
  word_t   aligned;

  // pick the addressed byte or halfword and extend it to a register value
  function automatic word_t align_load(input word_t data, input lq_acc_t acc);
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    word_t       res;
    byte_val = data[8*acc.addr_lo +: 8];
    half_val = data[16*acc.addr_lo[1] +: 16];
    case (acc.size)
      LQ_SZ_B:    res = {{24{byte_val[7]}}, byte_val};
      LQ_SZ_H:    res = {{16{half_val[15]}}, half_val};
      LQ_SZ_W:    res = data;
      LQ_SZ_BU:   res = {24'h0, byte_val};
      LQ_SZ_HU:   res = {16'h0, half_val};
      LQ_SZ_H_FP: res = {16'hffff, half_val}; // NaN boxing
      default:    res = data;
    endcase
    return res;
  endfunction

  assign ret_live    = i_ret.vld & ~i_ret.cancel;
  assign ret_is_load = i_is_load[i_ret_id];
  assign ret_at_head = (i_ret_id == i_rd_idx);
  assign ret_acc     = i_acc[i_ret_id]; // access recorded by the load's execute write
  assign aligned     = align_load(i_ret.data, ret_acc);

  // head return goes straight to the read port and is never written
  assign bypass = ret_live & ret_is_load & ret_at_head & ~i_bypass_disable;

  assign o_fill      = ret_live & ret_is_load & ~bypass;
  assign o_fill_id   = i_ret_id;
  assign o_fill_data = aligned;

  // head view, stored result unless a bypass is in flight
  assign o_lq_data_ready = i_ready[i_rd_idx] | bypass;
  assign o_lq_rddata     = bypass ? aligned : i_results[i_rd_idx];

  // register file forward ignores the bypass level, cancel is applied last
  assign o_lq_fwdvld  = i_ret.vld & ret_at_head & ret_is_load & ~i_ret.cancel;
  assign o_lq_fwdid   = i_rd_idx;
  assign o_lq_fwddata = aligned;

endmodule

// File: hw/lq_top.sv
// scalar load queue; no back-pressure, caller obeys full/empty and retires only on data ready
module lq_top import lq_pkg::*; #(
  parameter int LQ_DEPTH = 8,
  parameter int IDX_W    = $clog2(LQ_DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_reset_n,

  // allocation from decode
  input  logic             i_alloc,
  input  lq_info_t         i_alloc_info,
  output logic [IDX_W-1:0] o_nxt_id,

  // execute write carries the result of a non-load or the access of a load
  input  logic             i_ex_vld,
  input  logic [IDX_W-1:0] i_ex_id,
  input  lq_acc_t          i_ex_acc,
  input  word_t            i_ex_data,

  // memory return
  input  lq_ret_t          i_ret,
  input  logic [IDX_W-1:0] i_ret_id,
  input  logic             i_bypass_disable,

  // retire at head
  input  logic             i_lq_rden,
  output logic [IDX_W-1:0] o_lq_rdid,
  output lq_info_t         o_lq_rdinfo,
  output word_t            o_lq_rddata,
  output logic             o_lq_data_ready,

  // register file forward
  output logic             o_lq_fwdvld,
  output logic [IDX_W-1:0] o_lq_fwdid,
  output word_t            o_lq_fwddata,

  output logic             o_lq_full,
  output logic             o_lq_empty
);

  logic     [IDX_W-1:0]       wr_idx;
  logic     [IDX_W-1:0]       rd_idx;
  logic     [LQ_DEPTH-1:0]    ent_ready;
  logic     [LQ_DEPTH-1:0]    ent_is_load;
  lq_info_t [LQ_DEPTH-1:0]    info_entries;
  lq_acc_t  [LQ_DEPTH-1:0]    acc_entries;
  word_t    [LQ_DEPTH-1:0]    result_entries;
  logic                       ex_is_load;
  logic                       fill;
  logic     [IDX_W-1:0]       fill_id;
  word_t                      fill_data;
  logic     [1:0]             res_wr_en;
  logic     [1:0][IDX_W-1:0]  res_wr_idx;
  word_t    [1:0]             res_wr_value;

  lq_ptrs #(.LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) u_ptrs (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_alloc   (i_alloc),
    .i_retire  (i_lq_rden),
    .o_wr_idx  (wr_idx),
    .o_rd_idx  (rd_idx),
    .o_full    (o_lq_full),
    .o_empty   (o_lq_empty)
  );

  lq_entry_fsm #(.LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) u_entry_fsm (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc         (i_alloc),
    .i_wr_idx        (wr_idx),
    .i_retire        (i_lq_rden),
    .i_rd_idx        (rd_idx),
    .i_alloc_is_load (i_alloc_info.load),
    .i_ex_vld        (i_ex_vld),
    .i_ex_id         (i_ex_id),
    .i_ret_fill      (fill),
    .i_ret_id        (fill_id),
    .o_valid         (),
    .o_ready         (ent_ready),
    .o_is_load       (ent_is_load)
  );

  lq_store #(.ENTRY_T(lq_info_t), .NUM_WR(1), .LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) info_store (
    .i_clk      (i_clk),
    .i_wr_en    (i_alloc),
    .i_wr_idx   (wr_idx),
    .i_wr_value (i_alloc_info),
    .o_entries  (info_entries)
  );

  assign ex_is_load = ent_is_load[i_ex_id];

  lq_store #(.ENTRY_T(lq_acc_t), .NUM_WR(1), .LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) acc_store (
    .i_clk      (i_clk),
    .i_wr_en    (i_ex_vld & ex_is_load),
    .i_wr_idx   (i_ex_id),
    .i_wr_value (i_ex_acc),
    .o_entries  (acc_entries)
  );

  // port 0 takes the execute result of a non-load and port 1 the aligned return fill
  assign res_wr_en    = {fill, i_ex_vld & ~ex_is_load};
  assign res_wr_idx   = {fill_id, i_ex_id};
  assign res_wr_value = {fill_data, i_ex_data};

  lq_store #(.ENTRY_T(word_t), .NUM_WR(2), .LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) result_store (
    .i_clk      (i_clk),
    .i_wr_en    (res_wr_en),
    .i_wr_idx   (res_wr_idx),
    .i_wr_value (res_wr_value),
    .o_entries  (result_entries)
  );

  lq_return #(.LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) u_return (
    .i_ret            (i_ret),
    .i_ret_id         (i_ret_id),
    .i_bypass_disable (i_bypass_disable),
    .i_rd_idx         (rd_idx),
    .i_is_load        (ent_is_load),
    .i_ready          (ent_ready),
    .i_acc            (acc_entries),
    .i_results        (result_entries),
    .o_fill           (fill),
    .o_fill_id        (fill_id),
    .o_fill_data      (fill_data),
    .o_lq_data_ready  (o_lq_data_ready),
    .o_lq_rddata      (o_lq_rddata),
    .o_lq_fwdvld      (o_lq_fwdvld),
    .o_lq_fwdid       (o_lq_fwdid),
    .o_lq_fwddata     (o_lq_fwddata)
  );

  assign o_nxt_id    = wr_idx;
  assign o_lq_rdid   = rd_idx;
  assign o_lq_rdinfo = info_entries[rd_idx];

endmodule

// File: tb/tb_lq.sv
// load queue testbench; run from the project root so that tb/lq_testdata.txt is found
module tb_lq import lq_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LQ_DEPTH = 8;
  localparam int IDX_W    = 3;
  localparam int TIMEOUT  = 20; // cycles a retire may wait for data ready

  logic             i_clk;
  logic             i_reset_n;
  logic             i_alloc;
  lq_info_t         i_alloc_info;
  logic             i_ex_vld;
  logic [IDX_W-1:0] i_ex_id;
  lq_acc_t          i_ex_acc;
  word_t            i_ex_data;
  lq_ret_t          i_ret;
  logic [IDX_W-1:0] i_ret_id;
  logic             i_bypass_disable;
  logic             i_lq_rden;
  logic [IDX_W-1:0] o_nxt_id;
  logic [IDX_W-1:0] o_lq_rdid;
  logic [IDX_W-1:0] o_lq_fwdid;
  lq_info_t         o_lq_rdinfo;
  word_t            o_lq_rddata;
  word_t            o_lq_fwddata;
  logic             o_lq_data_ready;
  logic             o_lq_fwdvld;
  logic             o_lq_full;
  logic             o_lq_empty;

  // reference model of the queue
  logic        m_load  [LQ_DEPTH];
  logic [4:0]  m_rd    [LQ_DEPTH];
  logic        m_ready [LQ_DEPTH];
  lq_acc_t     m_acc   [LQ_DEPTH];
  word_t       m_data  [LQ_DEPTH];
  int          head;
  int          tail;
  int          count;
  logic        bypass_off;
  logic        exp_fwd;  // forward expected in the current cycle
  logic        exp_byp;
  int          errors;
  int          checks;
  int          test_errors;
  logic        aborted;
  logic [31:0] lfsr;
  int          q_id[$];  // returns held back for a shuffled send
  word_t       q_data[$];
  word_t       q_exp[$];

  lq_top #(.LQ_DEPTH(LQ_DEPTH), .IDX_W(IDX_W)) dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // expected register value of a load from the raw memory word
  function automatic word_t load_value(input word_t raw, input lq_acc_t acc);
    word_t b;
    word_t h;
    b = raw >> (8 * acc.addr_lo);
    h = acc.addr_lo[1] ? (raw >> 16) : raw; // halfword picked by bit 1 only
    case (acc.size)
      LQ_SZ_B:    return {{24{b[7]}}, b[7:0]};
      LQ_SZ_H:    return {{16{h[15]}}, h[15:0]};
      LQ_SZ_BU:   return {24'h0, b[7:0]};
      LQ_SZ_HU:   return {16'h0, h[15:0]};
      LQ_SZ_H_FP: return {16'hffff, h[15:0]};
      default:    return raw;
    endcase
  endfunction

  task automatic report_fault(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // new edge with all strobes dropped
  task automatic next_cycle();
    @(posedge i_clk);
    i_alloc    <= 1'b0;
    i_ex_vld   <= 1'b0;
    i_ret      <= '0;
    i_lq_rden  <= 1'b0;
  endtask

  task automatic check_status();
    expect_eq("o_lq_empty", o_lq_empty, count == 0);
    expect_eq("o_lq_full", o_lq_full, count == LQ_DEPTH);
    expect_eq("o_nxt_id", o_nxt_id, tail);
    expect_eq("o_lq_rdid", o_lq_rdid, head);
    expect_eq("o_lq_data_ready", o_lq_data_ready, m_ready[head] | exp_byp);
    expect_eq("o_lq_fwdvld", o_lq_fwdvld, exp_fwd);
  endtask

  task automatic retire_model();
    m_ready[head] = 1'b0;
    head = (head + 1) % LQ_DEPTH;
    count--;
  endtask

  task automatic alloc_entry(input logic load, input logic [4:0] rd);
    next_cycle();
    i_alloc      <= 1'b1;
    i_alloc_info <= '{load: load, rd: rd};
    @(negedge i_clk);
    check_status();
    m_load[tail]  = load;
    m_rd[tail]    = rd;
    m_ready[tail] = 1'b0;
    tail = (tail + 1) % LQ_DEPTH;
    count++;
  endtask

  task automatic exec_write(input int id, input logic [2:0] size, input logic [1:0] addr,
                            input word_t data);
    lq_acc_t acc;
    acc = '{size: lq_size_e'(size), addr_lo: addr};
    next_cycle();
    i_ex_vld  <= 1'b1;
    i_ex_id   <= IDX_W'(id);
    i_ex_acc  <= acc;
    i_ex_data <= data;
    @(negedge i_clk);
    check_status();
    if (m_load[id]) begin
      m_acc[id] = acc; // load keeps waiting for memory
    end else begin
      m_data[id]  = data;
      m_ready[id] = 1'b1;
    end
  endtask

  task automatic send_return(input int id, input word_t data, input logic cancel,
                             input word_t exp);
    word_t aligned;
    aligned = load_value(data, m_acc[id]);
    if (m_load[id] && aligned !== exp) begin
      report_fault($sformatf("testdata expects %h for entry %0d, alignment gives %h",
                             exp, id, aligned));
    end
    exp_fwd = !cancel && m_load[id] && (id == head);
    exp_byp = exp_fwd && !bypass_off;
    next_cycle();
    i_ret     <= '{vld: 1'b1, cancel: cancel, data: data};
    i_ret_id  <= IDX_W'(id);
    i_lq_rden <= exp_byp; // bypassed word is only seen in this cycle
    @(negedge i_clk);
    check_status();
    if (exp_fwd) begin
      expect_eq("o_lq_fwddata", o_lq_fwddata, exp);
      expect_eq("o_lq_fwdid", o_lq_fwdid, head);
    end
    if (exp_byp) begin
      expect_eq("o_lq_rddata", o_lq_rddata, exp);
      retire_model();
    end else if (!cancel && m_load[id]) begin
      m_data[id]  = aligned;
      m_ready[id] = 1'b1;
    end
    exp_fwd = 1'b0;
    exp_byp = 1'b0;
  endtask

  task automatic flush_returns();
    int r;
    int k;
    while (q_id.size() > 0) begin
      r = 0;
      for (int b = 0; b < 3; b++) begin
        r = (r << 1) | lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
      k = r % q_id.size();
      send_return(q_id[k], q_data[k], 1'b0, q_exp[k]);
      q_id.delete(k);
      q_data.delete(k);
      q_exp.delete(k);
    end
  endtask

  task automatic retire_check(input word_t exp);
    int waited;
    waited = 0;
    next_cycle();
    @(negedge i_clk);
    while (!o_lq_data_ready && waited < TIMEOUT) begin
      next_cycle();
      @(negedge i_clk);
      waited++;
    end
    if (!o_lq_data_ready) begin
      $display("timeout: head entry %0d never became ready", head);
      aborted = 1'b1;
    end else begin
      if (waited != 0) begin
        report_fault($sformatf("data ready of entry %0d came %0d cycles late", head, waited));
      end
      if (m_data[head] !== exp) begin
        report_fault($sformatf("testdata expects %h, model holds %h", exp, m_data[head]));
      end
      @(posedge i_clk);
      i_lq_rden <= 1'b1;
      @(negedge i_clk);
      check_status();
      expect_eq("o_lq_rddata", o_lq_rddata, exp);
      expect_eq("o_lq_rdinfo", o_lq_rdinfo, {m_load[head], m_rd[head]});
      retire_model();
    end
  endtask

  initial begin
    string       line;
    int          fd;
    logic [7:0]  op;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    i_reset_n        = 1'b0;
    i_alloc          = 1'b0;
    i_alloc_info     = '0;
    i_ex_vld         = 1'b0;
    i_ex_id          = '0;
    i_ex_acc         = '0;
    i_ex_data        = '0;
    i_ret            = '0;
    i_ret_id         = '0;
    i_bypass_disable = 1'b0;
    i_lq_rden        = 1'b0;
    for (int e = 0; e < LQ_DEPTH; e++) begin
      m_load[e]  = 1'b0;
      m_ready[e] = 1'b0;
    end
    head        = 0;
    tail        = 0;
    count       = 0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    bypass_off  = 1'b0;
    exp_fwd     = 1'b0;
    exp_byp     = 1'b0;
    aborted     = 1'b0;
    lfsr = 32'h520b9db5;
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    fd = $fopen("tb/lq_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/lq_testdata.txt");
      aborted = 1'b1;
    end
    while (!aborted && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      op = line.getc(0);
      f0 = '0;
      f1 = '0;
      f2 = '0;
      f3 = '0;
      void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3));
      case (op)
        "A": alloc_entry(f0[0], f1[4:0]);
        "E": exec_write(f0, f1[2:0], f2[1:0], f3);
        "R": send_return(f0, f1, f2[0], f3);
        "L": begin
          q_id.push_back(f0);
          q_data.push_back(f1);
          q_exp.push_back(f2);
        end
        "P": flush_returns();
        "D": retire_check(f0);
        "B": begin
          next_cycle();
          i_bypass_disable <= f0[0];
          bypass_off = f0[0];
          @(negedge i_clk);
          check_status();
        end
        "T": begin
          next_cycle();
          @(negedge i_clk);
          check_status();
          $display("test %0d %s, %0d errors", f0, (test_errors == 0) ? "ok" : "failed",
                   test_errors);
          test_errors = 0;
        end
        default: report_fault($sformatf("unknown operation '%c' in testdata", op));
      endcase
    end
    if (fd != 0) $fclose(fd);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/lq_pkg.sv
hw/lq_ptrs.sv
hw/lq_entry_fsm.sv
hw/lq_store.sv
hw/lq_return.sv
hw/lq_top.sv
tb/tb_lq.sv

// File: tb/lq_testdata.txt
# A load rd | E id size addr data | R id data cancel expect | L id data expect | P | D expect
# B bypass_disable | T test_number ; all fields hex, L queues a return and P sends them shuffled
A 0 01
A 1 02
A 1 03
A 0 04
A 1 05
A 1 06
A 1 07
A 1 08
T 1
E 0 0 0 11223344
E 1 0 3 00000000
E 2 1 2 00000000
E 3 0 0 cafef00d
E 4 2 0 00000000
E 5 4 1 00000000
E 6 5 2 00000000
E 7 6 0 00000000
L 1 80ff7f01 ffffff80
L 2 9abc1234 ffff9abc
L 4 deadbeef deadbeef
L 5 0000a500 000000a5
L 6 f00d1234 0000f00d
L 7 55553c00 ffff3c00
P
D 11223344
D ffffff80
D ffff9abc
D cafef00d
D deadbeef
D 000000a5
D 0000f00d
D ffff3c00
T 2
B 0
A 1 0a
E 0 1 0 00000000
R 0 12348765 0 ffff8765
T 3
B 1
A 1 0b
E 1 0 2 00000000
R 1 007f0000 0 0000007f
D 0000007f
T 4
A 1 0c
E 2 4 3 00000000
R 2 ab000000 1 000000ab
R 2 cd000000 0 000000cd
D 000000cd
T 5
